/* common/sblk_pkg.sv */
// Shared widths, depths and word types of the super-block unit, referenced by scoped name
`default_nettype none

package sblk_pkg;

   // Activation word and per-tile activation buffer
   localparam int ACT_W      = 16;
   localparam int ACT_ADDR_W = 6;
   localparam int ACT_DEPTH  = 1 << ACT_ADDR_W;

   // Weight word and per-tile weight buffer
   localparam int W_W        = 16;
   localparam int W_ADDR_W   = 6;
   localparam int W_DEPTH    = 1 << W_ADDR_W;

   // Partial sums wrap at this width
   localparam int PSUM_W      = 32;
   localparam int PSUM_ADDR_W = 9;
   localparam int PSUM_DEPTH  = 1 << PSUM_ADDR_W;

   // Signed data words
   typedef logic signed [ACT_W-1:0]  act_t;
   typedef logic signed [W_W-1:0]    wgt_t;
   typedef logic signed [PSUM_W-1:0] psum_t;

   // Buffer addresses
   typedef logic [ACT_ADDR_W-1:0]  act_addr_t;
   typedef logic [W_ADDR_W-1:0]    w_addr_t;
   typedef logic [PSUM_ADDR_W-1:0] psum_addr_t;

endpackage

`default_nettype wire

/* rtl/act_dist.sv */
// Input side of the unit; delays activation writes per tile group and skews read addresses
`timescale 1ns/1ps
`default_nettype none

module act_dist #(
   parameter int N_TILE   = 8,
   parameter int WR_GROUP = 4,
   localparam int N_GRP   = (N_TILE + WR_GROUP - 1) / WR_GROUP
) (
   input  wire                                  clk_h,
   input  wire                                  rst_n,
   input  wire sblk_pkg::act_t                  act_wr_data,
   input  wire sblk_pkg::act_addr_t             act_wr_addr,
   input  wire [N_TILE-1:0]                     act_wr_en,
   input  wire sblk_pkg::act_addr_t             act_rd_addr,
   input  wire sblk_pkg::w_addr_t               w_rd_addr,
   output sblk_pkg::act_t      [N_GRP-1:0]      grp_wr_data,
   output sblk_pkg::act_addr_t [N_GRP-1:0]      grp_wr_addr,
   output logic                [N_TILE-1:0]     tile_wr_en,
   output sblk_pkg::act_addr_t [N_TILE-1:0]     tile_act_rd_addr,
   output sblk_pkg::w_addr_t   [N_TILE-1:0]     tile_w_rd_addr
);

   // Full enable vector carried along each group stage
   logic [N_GRP-1:0][N_TILE-1:0] grp_wr_en;

   // Write delay chain
   // Stage g loads at E+g, group g stores at E+g+1
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         grp_wr_data <= '0;
         grp_wr_addr <= '0;
         grp_wr_en   <= '0;
      end else begin
         grp_wr_data[0] <= act_wr_data;
         grp_wr_addr[0] <= act_wr_addr;
         grp_wr_en[0]   <= act_wr_en;
         for (int g = 1; g < N_GRP; g++) begin
            grp_wr_data[g] <= grp_wr_data[g-1];
            grp_wr_addr[g] <= grp_wr_addr[g-1];
            grp_wr_en[g]   <= grp_wr_en[g-1];
         end
      end
   end

   // Each tile picks its own bit out of its group's stage
   always_comb begin
      for (int k = 0; k < N_TILE; k++) begin
         tile_wr_en[k] = grp_wr_en[k / WR_GROUP][k];
      end
   end

   // Read address skew
   // Stage k loads at E+k, tile k registers it at E+k+1
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         tile_act_rd_addr <= '0;
         tile_w_rd_addr   <= '0;
      end else begin
         tile_act_rd_addr[0] <= act_rd_addr;
         tile_w_rd_addr[0]   <= w_rd_addr;
         for (int k = 1; k < N_TILE; k++) begin
            tile_act_rd_addr[k] <= tile_act_rd_addr[k-1];
            tile_w_rd_addr[k]   <= tile_w_rd_addr[k-1];
         end
      end
   end

   // Unknown enables or addresses would smear X down the whole row
   a_ctrl_known: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !$isunknown({act_wr_en, act_rd_addr})
   ) else $error("act_dist: act_wr_en or act_rd_addr unknown");

endmodule

`default_nettype wire

/* rtl/psum_buffer.sv */
// Output side of the unit; stores chain results and reads sums back to tile 0 and the port
`timescale 1ns/1ps
`default_nettype none

module psum_buffer (
   input  wire                        clk_h,
   input  wire                        rst_n,
   input  wire sblk_pkg::psum_t       chain_sum,
   input  wire sblk_pkg::psum_addr_t  psum_wr_addr,
   input  wire                        psum_wr_en,
   input  wire sblk_pkg::psum_addr_t  psum_rd_addr,
   output sblk_pkg::psum_t            rd_data
);

   sblk_pkg::psum_t      mem [sblk_pkg::PSUM_DEPTH];

   // Write stage, sampled at E+N_TILE+3
   sblk_pkg::psum_t      wr_data_q;
   sblk_pkg::psum_addr_t wr_addr_q;
   logic                 wr_en_q;

   // Read pipe: address at E, array read at E+1, output at E+2
   sblk_pkg::psum_addr_t rd_addr_q;
   sblk_pkg::psum_t      mem_rd_q;

   // Buffer powers up cleared, like an initialized block RAM
   initial begin
      for (int i = 0; i < sblk_pkg::PSUM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Chain result registered together with its address and enable
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_data_q <= '0;
         wr_addr_q <= '0;
         wr_en_q   <= 1'b0;
      end else begin
         wr_data_q <= chain_sum;
         wr_addr_q <= psum_wr_addr;
         wr_en_q   <= psum_wr_en;
      end
   end

   // Array update one edge after sampling
   always_ff @(posedge clk_h) begin
      if (wr_en_q) begin
         mem[wr_addr_q] <= wr_data_q;
      end
   end

   // Read side; old data is returned on a same-edge write
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_addr_q <= '0;
         mem_rd_q  <= '0;
         rd_data   <= '0;
      end else begin
         rd_addr_q <= psum_rd_addr;
         mem_rd_q  <= mem[rd_addr_q];
         rd_data   <= mem_rd_q;
      end
   end

   // An unknown enable here would corrupt a random entry one edge later
   a_wr_en_known: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !$isunknown(psum_wr_en)
   ) else $error("psum_buffer: psum_wr_en unknown");

endmodule

`default_nettype wire

/* rtl/sblk_unit.sv */
// Top level of one super-block unit; instantiate with N_TILE and WR_GROUP set per design
`timescale 1ns/1ps
`default_nettype none

module sblk_unit #(
   parameter int N_TILE   = 8,
   parameter int WR_GROUP = 4
) (
   input  wire                        clk_h,
   input  wire                        rst_n,
   // Activation buffer write, one enable bit per tile
   input  wire sblk_pkg::act_t        act_wr_data,
   input  wire sblk_pkg::act_addr_t   act_wr_addr,
   input  wire [N_TILE-1:0]           act_wr_en,
   // Weight buffer write, taken at the sampling edge
   input  wire sblk_pkg::wgt_t        w_wr_data,
   input  wire sblk_pkg::w_addr_t     w_wr_addr,
   input  wire [N_TILE-1:0]           w_wr_en,
   // Read pass
   input  wire sblk_pkg::act_addr_t   act_rd_addr,
   input  wire sblk_pkg::w_addr_t     w_rd_addr,
   input  wire sblk_pkg::psum_addr_t  psum_rd_addr,
   // Write-back of the chain result, aligned to E+N_TILE+3
   input  wire sblk_pkg::psum_addr_t  psum_wr_addr,
   input  wire                        psum_wr_en,
   output sblk_pkg::psum_t            psum_rd_data
);

   // Number of activation-write delay groups
   localparam int N_GRP = (N_TILE + WR_GROUP - 1) / WR_GROUP;

   // Delayed activation writes, one set per group
   sblk_pkg::act_t      [N_GRP-1:0]  grp_wr_data;
   sblk_pkg::act_addr_t [N_GRP-1:0]  grp_wr_addr;
   logic                [N_TILE-1:0] tile_wr_en;

   // Skewed read addresses, one per tile
   sblk_pkg::act_addr_t [N_TILE-1:0] tile_act_rd_addr;
   sblk_pkg::w_addr_t   [N_TILE-1:0] tile_w_rd_addr;

   // Result of the last tile
   sblk_pkg::psum_t                  chain_sum;

   // Input side
   act_dist #(
      .N_TILE   (N_TILE),
      .WR_GROUP (WR_GROUP)
   ) act_dist_i (
      .clk_h            (clk_h),
      .rst_n            (rst_n),
      .act_wr_data      (act_wr_data),
      .act_wr_addr      (act_wr_addr),
      .act_wr_en        (act_wr_en),
      .act_rd_addr      (act_rd_addr),
      .w_rd_addr        (w_rd_addr),
      .grp_wr_data      (grp_wr_data),
      .grp_wr_addr      (grp_wr_addr),
      .tile_wr_en       (tile_wr_en),
      .tile_act_rd_addr (tile_act_rd_addr),
      .tile_w_rd_addr   (tile_w_rd_addr)
   );

   // MAC tile row, fed from the buffer read port at tile 0
   tile_chain #(
      .N_TILE   (N_TILE),
      .WR_GROUP (WR_GROUP)
   ) tile_chain_i (
      .clk_h            (clk_h),
      .rst_n            (rst_n),
      .grp_wr_data      (grp_wr_data),
      .grp_wr_addr      (grp_wr_addr),
      .tile_wr_en       (tile_wr_en),
      .tile_act_rd_addr (tile_act_rd_addr),
      .tile_w_rd_addr   (tile_w_rd_addr),
      .w_wr_data        (w_wr_data),
      .w_wr_addr        (w_wr_addr),
      .w_wr_en          (w_wr_en),
      .sum_in           (psum_rd_data),
      .sum_out          (chain_sum)
   );

   // Output side, read port also closes the accumulation loop
   psum_buffer psum_buffer_i (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .chain_sum    (chain_sum),
      .psum_wr_addr (psum_wr_addr),
      .psum_wr_en   (psum_wr_en),
      .psum_rd_addr (psum_rd_addr),
      .rd_data      (psum_rd_data)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits non-zero unless the run passed

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      -f sim.f --top-module tb_sblk_unit -o sim_tb; then
   echo "Verilator build did not complete"
   exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" <<< "$out"; then
   exit 0
fi
exit 1

/* sim.f */
common/sblk_pkg.sv
rtl/act_dist.sv
tile_chain/mac_tile.sv
tile_chain/tile_chain.sv
rtl/psum_buffer.sv
rtl/sblk_unit.sv
tests/tb_sblk_unit.sv

/* tests/tb_sblk_unit.sv */
// Directed testbench for the super-block unit; compile with sim.f and run tb_sblk_unit as top
`timescale 1ns/1ps
`default_nettype none

module tb_sblk_unit;

   localparam int N_TILE     = 8;
   localparam int WR_GROUP   = 4;
   localparam int N_GRP      = (N_TILE + WR_GROUP - 1) / WR_GROUP;
   localparam int CLK_PERIOD = 40;
   localparam int SEED       = 32'h893d0d9a;
   // Loaded activation and weight entries per tile
   localparam int NUM_ADDR   = 16;
   // Parked read address, holds zero in every tile
   localparam int IDLE_ADDR  = 63;
   // Cycles from a pass's sampling edge to its write-back edge
   localparam int PIPE       = N_TILE + 3;
   localparam int TEST_CYC   = 8 + (1 + PIPE) + (N_TILE * NUM_ADDR + N_GRP + 1) + 24
                               + 4 * (PIPE + 4) + 5 * PIPE + (N_GRP + 3) + (N_GRP + 2);
   localparam int WATCHDOG_NS = 2 * TEST_CYC * CLK_PERIOD;

   logic                 clk_h;
   logic                 rst_n;
   sblk_pkg::act_t       act_wr_data;
   sblk_pkg::act_addr_t  act_wr_addr;
   logic [N_TILE-1:0]    act_wr_en;
   sblk_pkg::wgt_t       w_wr_data;
   sblk_pkg::w_addr_t    w_wr_addr;
   logic [N_TILE-1:0]    w_wr_en;
   sblk_pkg::act_addr_t  act_rd_addr;
   sblk_pkg::w_addr_t    w_rd_addr;
   sblk_pkg::psum_addr_t psum_rd_addr;
   sblk_pkg::psum_addr_t psum_wr_addr;
   logic                 psum_wr_en;
   sblk_pkg::psum_t      psum_rd_data;

   // Reference copies of every tile buffer and the sum buffer
   sblk_pkg::act_t  act_m  [N_TILE][sblk_pkg::ACT_DEPTH];
   sblk_pkg::wgt_t  w_m    [N_TILE][sblk_pkg::W_DEPTH];
   sblk_pkg::psum_t psum_m [sblk_pkg::PSUM_DEPTH];

   // Pending passes: activation, weight, sum read and sum write addresses
   int p_act[$];
   int p_w[$];
   int p_rd[$];
   int p_wr[$];

   int errors = 0;
   int checks = 0;

   sblk_unit #(
      .N_TILE   (N_TILE),
      .WR_GROUP (WR_GROUP)
   ) sblk_unit_i (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .act_wr_data  (act_wr_data),
      .act_wr_addr  (act_wr_addr),
      .act_wr_en    (act_wr_en),
      .w_wr_data    (w_wr_data),
      .w_wr_addr    (w_wr_addr),
      .w_wr_en      (w_wr_en),
      .act_rd_addr  (act_rd_addr),
      .w_rd_addr    (w_rd_addr),
      .psum_rd_addr (psum_rd_addr),
      .psum_wr_addr (psum_wr_addr),
      .psum_wr_en   (psum_wr_en),
      .psum_rd_data (psum_rd_data)
   );

   initial begin
      clk_h = 1'b0;
      forever #(CLK_PERIOD / 2) clk_h = ~clk_h;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   // Inputs change 2 ns after the rising edge
   task automatic tick();
      @(posedge clk_h);
      #2;
   endtask

   function automatic logic [15:0] rand_word();
      int unsigned r;
      r = $urandom();
      return r[15:0];
   endfunction

   task automatic check_value(input string name, input sblk_pkg::psum_t got,
                              input sblk_pkg::psum_t exp);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      if (errors == err_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - err_start);
      end
   endtask

   // One write edge, same word to every enabled tile
   task automatic write_tiles(input int a_addr, input sblk_pkg::act_t a_data,
                              input logic [N_TILE-1:0] a_en, input int w_addr,
                              input sblk_pkg::wgt_t w_data, input logic [N_TILE-1:0] w_en);
      act_wr_addr = sblk_pkg::act_addr_t'(a_addr);
      act_wr_data = a_data;
      act_wr_en   = a_en;
      w_wr_addr   = sblk_pkg::w_addr_t'(w_addr);
      w_wr_data   = w_data;
      w_wr_en     = w_en;
      for (int k = 0; k < N_TILE; k++) begin
         if (a_en[k]) act_m[k][a_addr] = a_data;
         if (w_en[k]) w_m[k][w_addr] = w_data;
      end
      tick();
      act_wr_en = '0;
      w_wr_en   = '0;
   endtask

   // Address at E, data valid after E+2
   task automatic read_psum(input int addr, output sblk_pkg::psum_t val);
      psum_rd_addr = sblk_pkg::psum_addr_t'(addr);
      repeat (3) tick();
      val = psum_rd_data;
   endtask

   // Old entry plus the dot product over the tile row, wrapped at 32 bits
   function automatic sblk_pkg::psum_t expected_sum(input int rd, input int aa, input int wa);
      int s;
      s = psum_m[rd];
      for (int k = 0; k < N_TILE; k++) begin
         s = s + int'(act_m[k][aa]) * int'(w_m[k][wa]);
      end
      return sblk_pkg::psum_t'(s);
   endfunction

   task automatic add_pass(input int aa, input int wa, input int rd, input int wr);
      p_act.push_back(aa);
      p_w.push_back(wa);
      p_rd.push_back(rd);
      p_wr.push_back(wr);
   endtask

   // Issue queued passes on consecutive edges, write back each at E+N_TILE+3, read back
   task automatic run_passes();
      int n;
      sblk_pkg::psum_t exp[$];
      sblk_pkg::psum_t got;
      n = p_act.size();
      for (int i = 0; i < n; i++) exp.push_back(expected_sum(p_rd[i], p_act[i], p_w[i]));
      for (int t = 0; t < n + PIPE; t++) begin
         if (t < n) begin
            act_rd_addr  = sblk_pkg::act_addr_t'(p_act[t]);
            w_rd_addr    = sblk_pkg::w_addr_t'(p_w[t]);
            psum_rd_addr = sblk_pkg::psum_addr_t'(p_rd[t]);
         end else begin
            act_rd_addr  = sblk_pkg::act_addr_t'(IDLE_ADDR);
            w_rd_addr    = sblk_pkg::w_addr_t'(IDLE_ADDR);
            psum_rd_addr = '0;
         end
         psum_wr_en = (t >= PIPE);
         if (t >= PIPE) psum_wr_addr = sblk_pkg::psum_addr_t'(p_wr[t-PIPE]);
         tick();
      end
      psum_wr_en = 1'b0;
      for (int i = 0; i < n; i++) psum_m[p_wr[i]] = exp[i];
      for (int i = 0; i < n; i++) begin
         read_psum(p_wr[i], got);
         check_value("psum_rd_data", got, exp[i]);
      end
      p_act.delete();
      p_w.delete();
      p_rd.delete();
      p_wr.delete();
   endtask

   // Zero the parked entry first, then fill the working entries one tile at a time
   task automatic load_buffers();
      logic [N_TILE-1:0] one_hot;
      write_tiles(IDLE_ADDR, '0, '1, IDLE_ADDR, '0, '1);
      act_rd_addr = sblk_pkg::act_addr_t'(IDLE_ADDR);
      w_rd_addr   = sblk_pkg::w_addr_t'(IDLE_ADDR);
      repeat (PIPE) tick();
      for (int a = 0; a < NUM_ADDR; a++) begin
         for (int k = 0; k < N_TILE; k++) begin
            one_hot    = '0;
            one_hot[k] = 1'b1;
            write_tiles(a, rand_word(), one_hot, a, rand_word(), one_hot);
         end
      end
      repeat (N_GRP + 1) tick();
   endtask

   task automatic reset_state();
      int err_start;
      sblk_pkg::psum_t got;
      err_start = errors;
      for (int i = 0; i < 8; i++) begin
         read_psum(int'($urandom() % sblk_pkg::PSUM_DEPTH), got);
         check_value("psum_rd_data", got, '0);
      end
      report_test("reset", err_start);
   endtask

   task automatic single_pass();
      int err_start;
      err_start = errors;
      load_buffers();
      add_pass(3, 7, 10, 20);
      run_passes();
      report_test("single pass", err_start);
   endtask

   // Reads its own earlier result and adds to it
   task automatic accumulation();
      int err_start;
      err_start = errors;
      add_pass(9, 2, 20, 20);
      run_passes();
      report_test("accumulation", err_start);
   endtask

   task automatic back_to_back();
      int err_start;
      err_start = errors;
      for (int i = 0; i < PIPE; i++) add_pass(i % NUM_ADDR, (i + 5) % NUM_ADDR, 20 + i, 100 + i);
      run_passes();
      report_test("back-to-back", err_start);
   endtask

   // Pass sampled exactly N_GRP+1 edges after the broadcast write
   task automatic grouped_write();
      int err_start;
      err_start = errors;
      write_tiles(5, rand_word(), '1, 0, '0, '0);
      repeat (N_GRP) tick();
      add_pass(5, 11, 0, 120);
      run_passes();
      report_test("grouped write delay", err_start);
   endtask

   // Sums pass 2^31 inside the row and wrap
   task automatic wrap_around();
      int err_start;
      err_start = errors;
      write_tiles(40, 16'sh8000, '1, 40, 16'sh8000, '1);
      write_tiles(41, 16'sh7fff, '1, 41, 16'sh8000, '1);
      repeat (N_GRP + 1) tick();
      add_pass(40, 40, 20, 210);
      run_passes();
      add_pass(41, 41, 210, 210);
      run_passes();
      report_test("wrap-around", err_start);
   endtask

   initial begin
      void'($urandom(SEED));
      rst_n        = 1'b0;
      act_wr_data  = '0;
      act_wr_addr  = '0;
      act_wr_en    = '0;
      w_wr_data    = '0;
      w_wr_addr    = '0;
      w_wr_en      = '0;
      act_rd_addr  = '0;
      w_rd_addr    = '0;
      psum_rd_addr = '0;
      psum_wr_addr = '0;
      psum_wr_en   = 1'b0;
      for (int i = 0; i < sblk_pkg::PSUM_DEPTH; i++) psum_m[i] = '0;
      repeat (8) @(posedge clk_h);
      #2;
      rst_n = 1'b1;
      reset_state();
      single_pass();
      accumulation();
      back_to_back();
      grouped_write();
      wrap_around();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tile_chain/mac_tile.sv */
// One MAC tile of the row; reads its buffers, multiplies and adds the upstream partial sum
`timescale 1ns/1ps
`default_nettype none

module mac_tile (
   input  wire                        clk_h,
   input  wire                        rst_n,
   input  wire sblk_pkg::act_t        act_wr_data,
   input  wire sblk_pkg::act_addr_t   act_wr_addr,
   input  wire                        act_wr_en,
   input  wire sblk_pkg::wgt_t        w_wr_data,
   input  wire sblk_pkg::w_addr_t     w_wr_addr,
   input  wire                        w_wr_en,
   input  wire sblk_pkg::act_addr_t   act_rd_addr,
   input  wire sblk_pkg::w_addr_t     w_rd_addr,
   input  wire sblk_pkg::psum_t       sum_in,
   output sblk_pkg::psum_t            sum_out
);

   // Local buffers
   sblk_pkg::act_t      act_mem [sblk_pkg::ACT_DEPTH];
   sblk_pkg::wgt_t      w_mem   [sblk_pkg::W_DEPTH];

   // Read address registers, loaded at E+k+1
   sblk_pkg::act_addr_t act_rd_addr_q;
   sblk_pkg::w_addr_t   w_rd_addr_q;

   // Buffer output registers, loaded at E+k+2
   sblk_pkg::act_t      act_q;
   sblk_pkg::wgt_t      w_q;

   // Product and accumulate register
   sblk_pkg::psum_t     prod;
   sblk_pkg::psum_t     acc_q;

   // Activation buffer write port
   always_ff @(posedge clk_h) begin
      if (act_wr_en) begin
         act_mem[act_wr_addr] <= act_wr_data;
      end
   end

   // Weight buffer write port
   always_ff @(posedge clk_h) begin
      if (w_wr_en) begin
         w_mem[w_wr_addr] <= w_wr_data;
      end
   end

   // Synchronous reads
   // address stage then data stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         act_rd_addr_q <= '0;
         w_rd_addr_q   <= '0;
         act_q         <= '0;
         w_q           <= '0;
      end else begin
         act_rd_addr_q <= act_rd_addr;
         w_rd_addr_q   <= w_rd_addr;
         act_q         <= act_mem[act_rd_addr_q];
         w_q           <= w_mem[w_rd_addr_q];
      end
   end

   // Both operands widened first, 16x16 signed fits in 32 bits
   assign prod = sblk_pkg::psum_t'(act_q) * sblk_pkg::psum_t'(w_q);

   // Accumulate at E+k+3, wraps at PSUM_W
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         acc_q <= '0;
      end else begin
         acc_q <= prod + sum_in;
      end
   end

   assign sum_out = acc_q;

   // Delayed group write landing on the entry being read out this edge
   a_act_no_collision: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !(act_wr_en && (act_wr_addr == act_rd_addr_q))
   ) else $error("mac_tile: activation write and read hit the same entry");

endmodule

`default_nettype wire

/* tile_chain/tile_chain.sv */
// Row of MAC tiles; instantiated by the unit top, cascades partial sums tile to tile
`timescale 1ns/1ps
`default_nettype none

module tile_chain #(
   parameter int N_TILE   = 8,
   parameter int WR_GROUP = 4,
   localparam int N_GRP   = (N_TILE + WR_GROUP - 1) / WR_GROUP
) (
   input  wire                                  clk_h,
   input  wire                                  rst_n,
   input  wire sblk_pkg::act_t      [N_GRP-1:0] grp_wr_data,
   input  wire sblk_pkg::act_addr_t [N_GRP-1:0] grp_wr_addr,
   input  wire [N_TILE-1:0]                     tile_wr_en,
   input  wire sblk_pkg::act_addr_t [N_TILE-1:0] tile_act_rd_addr,
   input  wire sblk_pkg::w_addr_t  [N_TILE-1:0] tile_w_rd_addr,
   input  wire sblk_pkg::wgt_t                  w_wr_data,
   input  wire sblk_pkg::w_addr_t               w_wr_addr,
   input  wire [N_TILE-1:0]                     w_wr_en,
   input  wire sblk_pkg::psum_t                 sum_in,
   output sblk_pkg::psum_t                      sum_out
);

   // Cascade taps, casc[k] feeds tile k
   sblk_pkg::psum_t [N_TILE:0] casc;

   assign casc[0] = sum_in;

   for (genvar k = 0; k < N_TILE; k++) begin : g_tile
      // Activation writes come from the group stage, weights straight in
      mac_tile mac_tile_i (
         .clk_h       (clk_h),
         .rst_n       (rst_n),
         .act_wr_data (grp_wr_data[k / WR_GROUP]),
         .act_wr_addr (grp_wr_addr[k / WR_GROUP]),
         .act_wr_en   (tile_wr_en[k]),
         .w_wr_data   (w_wr_data),
         .w_wr_addr   (w_wr_addr),
         .w_wr_en     (w_wr_en[k]),
         .act_rd_addr (tile_act_rd_addr[k]),
         .w_rd_addr   (tile_w_rd_addr[k]),
         .sum_in      (casc[k]),
         .sum_out     (casc[k+1])
      );
   end

   // Last tile, valid after E+N_TILE+2
   assign sum_out = casc[N_TILE];

endmodule

`default_nettype wire
